/* dv/icache_mem_model.sv */
// ------------------------------------------------------------
// AXI read slave model answering line bursts with data built
// from each beat's address and random RVALID gaps
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icache_mem_model #(
   parameter int          DRV_DLY = 2,
   parameter logic [31:0] SEED    = 32'h12b9
) (
   input  wire                      clk,
   input  wire  [7:0]               i_max_gap,   // Longest RVALID gap in cycles
   input  wire                      i_arvalid,
   output logic                     o_arready,
   input  wire  icache_pkg::paddr_t i_araddr,
   input  wire  [7:0]               i_arlen,
   output logic                     o_rvalid,
   input  wire                      i_rready,
   output icache_pkg::fetch_t       o_rdata,
   output logic                     o_rlast
);
   import icache_pkg::*;

   paddr_t      base_addr;
   paddr_t      beat_addr;
   logic [7:0]  burst_len;
   int unsigned gap;
   int unsigned seed_val;

   initial
   begin
      seed_val  = $urandom(SEED);
      o_arready = 1'b0;
      o_rvalid  = 1'b0;
      o_rdata   = '0;
      o_rlast   = 1'b0;
      forever
      begin
         // Idle until a read request shows up
         @(posedge clk);
         while (i_arvalid !== 1'b1)
         begin
            @(posedge clk);
         end
         #DRV_DLY;
         o_arready = 1'b1;
         @(posedge clk);           // AR handshake edge
         base_addr = i_araddr;
         burst_len = i_arlen;
         #DRV_DLY;
         o_arready = 1'b0;

         for (int beat = 0; beat <= burst_len; beat++)
         begin
            gap = $urandom % (int'(i_max_gap) + 1);
            if (gap > 0)
            begin
               repeat (gap)
               begin
                  @(posedge clk);
               end
               #DRV_DLY;
            end
            // INCR burst, one fetch window per beat
            beat_addr = base_addr + paddr_t'(beat << P_FETCH_BYTES);
            o_rvalid  = 1'b1;
            o_rdata   = {beat_addr, ~beat_addr};
            o_rlast   = (beat == burst_len);
            @(posedge clk);
            while (i_rready !== 1'b1)
            begin
               @(posedge clk);
            end
            #DRV_DLY;
            o_rvalid = 1'b0;
            o_rlast  = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* dv/icache_props.sv */
// ------------------------------------------------------------
// Bound checks on AXI read handshake and frontend stall rules
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icache_props (
   input wire clk,
   input wire i_rst_n,
   input wire i_p_ce,
   input wire i_stall_req,
   input wire i_arvalid,
   input wire i_arready,
   input wire i_rready
);

   int assert_fail_cnt = 0;   // Read by the testbench at the end

   property p_arvalid_hold;
      @(posedge clk) disable iff (!i_rst_n)
         (i_arvalid && !i_arready) |=> i_arvalid;
   endproperty

   property p_rready_in_stall;
      @(posedge clk) disable iff (!i_rst_n)
         !i_stall_req |-> !i_rready;
   endproperty

   // Frontend must hold off while the cache is busy
   property p_no_fetch_in_stall;
      @(posedge clk) disable iff (!i_rst_n)
         i_stall_req |-> !i_p_ce;
   endproperty

   a_arvalid_hold: assert property (p_arvalid_hold)
   else
   begin
      assert_fail_cnt++;
      $error("ARVALID dropped before ARREADY");
   end

   a_rready_in_stall: assert property (p_rready_in_stall)
   else
   begin
      assert_fail_cnt++;
      $error("RREADY high while the cache is not stalled");
   end

   a_no_fetch_in_stall: assert property (p_no_fetch_in_stall)
   else
   begin
      assert_fail_cnt++;
      $error("Fetch enable high during stall");
   end

endmodule

bind icache_top icache_props u_props (
   .clk         (clk),
   .i_rst_n     (i_rst_n),
   .i_p_ce      (i_p_ce),
   .i_stall_req (o_stall_req),
   .i_arvalid   (o_arvalid),
   .i_arready   (i_arready),
   .i_rready    (o_rready)
);

`default_nettype wire

/* dv/icache_tb.sv */
// ------------------------------------------------------------
// Instruction cache testbench: clock, reset, directed tests,
// compare tasks, AR monitor and watchdog
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icache_tb;
   import icache_pkg::*;

   localparam int P_LINE      = 6;
   localparam int P_SETS      = 4;
   localparam int P_WAYS      = 1;
   localparam int NWAYS       = 1 << P_WAYS;
   localparam int WINDOWS     = 1 << (P_LINE - P_FETCH_BYTES);
   localparam int ARLEN_EXP   = WINDOWS - 1;
   localparam int DRV_DLY     = 2;
   localparam int RST_CYCLES  = 16;
   localparam int BOOT_LIMIT  = (1 << P_SETS) + 4;
   localparam int STALL_LIMIT = 1000;
   localparam int NUM_TESTS   = 5;
   localparam int WDOG_CYCLES = NUM_TESTS * 2000;

   logic       clk;
   logic       rst_n;
   logic       p_ce;
   vpo_t       vpo;
   ppn_t       ppn_s2;
   logic       icinv_we;
   paddr_t     icinv_addr;
   logic       stall_req;
   fetch_t     ins;
   logic       valid;
   logic       arready;
   logic       arvalid;
   paddr_t     araddr;
   logic [7:0] arlen;
   logic       rready;
   logic       rvalid;
   fetch_t     rdata;
   logic       rlast;
   logic [7:0] max_gap;

   int         err_count = 0;
   int         ar_count  = 0;
   paddr_t     last_araddr;
   logic [7:0] last_arlen;
   paddr_t     prev_paddr;   // Fetch whose offset sits in stage 1

   icache_top #(
      .P_LINE (P_LINE),
      .P_SETS (P_SETS),
      .P_WAYS (P_WAYS)
   ) u_dut (
      .clk          (clk),
      .i_rst_n      (rst_n),
      .i_p_ce       (p_ce),
      .i_vpo        (vpo),
      .i_ppn_s2     (ppn_s2),
      .i_icinv_we   (icinv_we),
      .i_icinv_addr (icinv_addr),
      .o_stall_req  (stall_req),
      .o_ins        (ins),
      .o_valid      (valid),
      .i_arready    (arready),
      .o_arvalid    (arvalid),
      .o_araddr     (araddr),
      .o_arlen      (arlen),
      .o_rready     (rready),
      .i_rvalid     (rvalid),
      .i_rdata      (rdata),
      .i_rlast      (rlast)
   );

   icache_mem_model #(
      .DRV_DLY (DRV_DLY),
      .SEED    (32'h12b9)
   ) u_mem (
      .clk       (clk),
      .i_max_gap (max_gap),
      .i_arvalid (arvalid),
      .o_arready (arready),
      .i_araddr  (araddr),
      .i_arlen   (arlen),
      .o_rvalid  (rvalid),
      .i_rready  (rready),
      .o_rdata   (rdata),
      .o_rlast   (rlast)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #20 clk = ~clk;

   // Count accepted read requests
   always @(posedge clk)
   begin
      if (rst_n && arvalid && arready)
      begin
         ar_count    <= ar_count + 1;
         last_araddr <= araddr;
         last_arlen  <= arlen;
      end
   end

   initial
   begin
      repeat (WDOG_CYCLES) @(posedge clk);
      $display("[ERROR] watchdog: run did not end within %0d cycles", WDOG_CYCLES);
      $display("tests failed");
      $finish;
   end

   // Memory returns the window address followed by its inverse
   function automatic fetch_t model_window(input paddr_t addr);
      paddr_t win;
      win = {addr[CONFIG_AW-1:P_FETCH_BYTES], {P_FETCH_BYTES{1'b0}}};
      return {win, ~win};
   endfunction

   task automatic check_fetch(input string name, input fetch_t exp, input fetch_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_count(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_addr(input string name, input paddr_t exp, input paddr_t act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
         err_count++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
         err_count++;
      end
   endtask

   task automatic wait_not_stalled(input string name);
      int cycles;
      cycles = 0;
      while (stall_req === 1'b1 && cycles < STALL_LIMIT)
      begin
         @(posedge clk);
         #DRV_DLY;
         cycles++;
      end
      if (stall_req !== 1'b0)
      begin
         $display("[ERROR] %s: cache still stalled after %0d cycles", name, STALL_LIMIT);
         err_count++;
      end
   endtask

   // First edge re-checks the previous fetch and the second resolves this one
   task automatic fetch_check(input string name, input paddr_t addr, input int exp_ar);
      int ar_before;
      ar_before = ar_count;
      wait_not_stalled(name);
      p_ce   = 1'b1;
      vpo    = addr[CONFIG_P_PAGE_SIZE-1:0];
      ppn_s2 = prev_paddr[CONFIG_AW-1:CONFIG_P_PAGE_SIZE];
      @(posedge clk);
      #DRV_DLY;
      ppn_s2 = addr[CONFIG_AW-1:CONFIG_P_PAGE_SIZE];
      @(posedge clk);
      #DRV_DLY;
      p_ce       = 1'b0;
      prev_paddr = addr;
      wait_not_stalled(name);
      check_flag(name, 1'b1, valid);
      check_fetch(name, model_window(addr), ins);
      if (exp_ar >= 0)
         check_count(name, exp_ar, ar_count - ar_before);
   endtask

   task automatic invalidate_line(input string name, input paddr_t addr);
      wait_not_stalled(name);
      icinv_we   = 1'b1;
      icinv_addr = addr;
      @(posedge clk);
      #DRV_DLY;
      icinv_we = 1'b0;
      if (stall_req !== 1'b1)
      begin
         $display("[ERROR] %s: invalidate request did not stall the cache", name);
         err_count++;
      end
      wait_not_stalled(name);
   endtask

   task automatic test_boot();
      int cycles;
      bit axi_busy;
      cycles   = 0;
      axi_busy = 1'b0;
      while (stall_req === 1'b1 && cycles <= BOOT_LIMIT)
      begin
         if (arvalid !== 1'b0 || rready !== 1'b0)
            axi_busy = 1'b1;
         @(posedge clk);
         #DRV_DLY;
         cycles++;
      end
      if (cycles > BOOT_LIMIT)
      begin
         $display("[ERROR] boot: stall did not end within %0d cycles", BOOT_LIMIT);
         err_count++;
      end
      repeat (4)
      begin
         if (arvalid !== 1'b0 || rready !== 1'b0)
            axi_busy = 1'b1;
         @(posedge clk);
         #DRV_DLY;
      end
      if (axi_busy)
      begin
         $display("[ERROR] boot: AXI read channel active during boot");
         err_count++;
      end
      check_count("boot", 0, ar_count);
      check_flag("boot", 1'b0, valid);   // No fetch issued yet
   endtask

   task automatic test_miss_hit();
      paddr_t line;
      line = 32'h0001_2340;   // Set 13
      // Critical word is window 3
      fetch_check("miss_hit", line + 32'h18, 1);
      check_addr("miss_hit", line, last_araddr);
      check_count("miss_hit", ARLEN_EXP, 32'(last_arlen));
      for (int w = 0; w < WINDOWS; w++)
         fetch_check("miss_hit", line + paddr_t'(w << P_FETCH_BYTES), 0);
   endtask

   task automatic test_replacement();
      paddr_t addrs [NWAYS+1];
      int     ar_before;
      for (int k = 0; k <= NWAYS; k++)
      begin
         addrs[k] = paddr_t'(32'h0010_0000 * (k + 1)) + paddr_t'(5 << P_LINE) +
                    paddr_t'((k % WINDOWS) << P_FETCH_BYTES);
      end
      ar_before = ar_count;
      for (int k = 0; k <= NWAYS; k++)
         fetch_check("replacement", addrs[k], 1);
      for (int k = 0; k <= NWAYS; k++)
         fetch_check("replacement", addrs[k], -1);
      // More tags than ways, so the second pass misses at least once
      if (ar_count - ar_before <= NWAYS + 1)
      begin
         $display("[ERROR] replacement: %0d read requests for %0d tags in %0d ways",
                  ar_count - ar_before, NWAYS + 1, NWAYS);
         err_count++;
      end
   endtask

   task automatic test_invalidate();
      paddr_t x_addr;
      paddr_t y_addr;
      x_addr = 32'h0001_2348;   // Cached by the miss test
      y_addr = 32'h0003_0080;   // Set 2
      fetch_check("invalidate", x_addr, 0);
      fetch_check("invalidate", y_addr, 1);
      invalidate_line("invalidate", x_addr);
      fetch_check("invalidate", x_addr, 1);
      fetch_check("invalidate", y_addr, 0);
   endtask

   task automatic test_backpressure();
      paddr_t addr;
      max_gap = 8'd12;
      for (int k = 0; k < 4; k++)
      begin
         addr = 32'h0200_0000 + paddr_t'(k * 32'h1000) + paddr_t'(k << P_LINE) +
                paddr_t'((WINDOWS - 1 - k) << P_FETCH_BYTES);
         fetch_check("backpressure", addr, 1);
      end
      max_gap = 8'd2;
   endtask

   initial
   begin
      rst_n      = 1'b0;
      p_ce       = 1'b0;
      vpo        = '0;
      ppn_s2     = '0;
      icinv_we   = 1'b0;
      icinv_addr = '0;
      max_gap    = 8'd2;
      prev_paddr = '0;

      repeat (RST_CYCLES) @(posedge clk);
      #DRV_DLY;
      rst_n = 1'b1;

      test_boot();
      test_miss_hit();
      test_replacement();
      test_invalidate();
      test_backpressure();

      $display("Check errors: %0d, assertion failures: %0d", err_count,
               u_dut.u_props.assert_fail_cnt);
      if (err_count == 0 && u_dut.u_props.assert_fail_cnt == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* icache.f */
source/icache_pkg.sv
source/icache_array_if.sv
source/icache_ways.sv
source/icache_ctrl.sv
source/icache_axi_rd.sv
source/icache_top.sv
dv/icache_mem_model.sv
dv/icache_props.sv
dv/icache_tb.sv

/* source/icache_array_if.sv */
// ------------------------------------------------------------
// Array port from the cache controller to the tag and payload
// arrays of every way
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface icache_array_if #(
   parameter int P_LINE = 6,
   parameter int P_SETS = 4,
   parameter int P_WAYS = 1
);
   import icache_pkg::*;

   localparam int NWAYS      = 1 << P_WAYS;
   localparam int TAG_W      = CONFIG_AW - P_SETS - P_LINE;
   localparam int PAYLOAD_AW = P_SETS + P_LINE - P_FETCH_BYTES;

   logic [P_SETS-1:0]     line_addr;     // Set index
   logic                  re;            // Shared by tag and payload
   logic [NWAYS-1:0]      tag_we;
   logic [TAG_W:0]        tag_wdata;     // {tag, valid}
   logic [PAYLOAD_AW-1:0] payload_addr;  // {set, window}
   logic [NWAYS-1:0]      payload_we;
   fetch_t                payload_wdata;

   modport ctrl (
      output line_addr, re, tag_we, tag_wdata,
      output payload_addr, payload_we, payload_wdata
   );

   modport ways (
      input line_addr, re, tag_we, tag_wdata,
      input payload_addr, payload_we, payload_wdata
   );

endinterface

`default_nettype wire

/* source/icache_axi_rd.sv */
// ------------------------------------------------------------
// AXI read channel: AR valid and address registers, R ready
// and beat strobes
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icache_axi_rd #(
   parameter int P_LINE = 6
) (
   input  wire                                     clk,
   input  wire                                     i_rst_n,
   input  wire                                     i_ar_req,
   input  wire icache_pkg::axi_addr_t              i_ar_addr,
   input  wire                                     i_arready,
   output logic                                    o_arvalid,
   output icache_pkg::axi_addr_t                   o_araddr,
   output logic [icache_pkg::AXI_LEN_W-1:0]        o_arlen,
   input  wire                                     i_in_refill,
   input  wire                                     i_rvalid,
   input  wire                                     i_rlast,
   output logic                                    o_rready,
   output logic                                    o_r_beat,
   output logic                                    o_r_last
);
   import icache_pkg::*;

   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         o_arvalid <= 1'b0;
      else if (i_ar_req)
         o_arvalid <= 1'b1;
      else if (o_arvalid && i_arready)
         o_arvalid <= 1'b0;   // Accepted by slave
   end

   always_ff @(posedge clk)
   begin
      if (i_ar_req)
         o_araddr <= i_ar_addr;
   end

   // One beat per fetch window
   assign o_arlen = AXI_LEN_W'((1 << (P_LINE - P_FETCH_BYTES)) - 1);

   assign o_rready = i_in_refill;
   assign o_r_beat = i_rvalid & o_rready;
   assign o_r_last = o_r_beat & i_rlast;

endmodule

`default_nettype wire

/* source/icache_ctrl.sv */
// ------------------------------------------------------------
// Cache controller: main FSM, boot and refill counters, clock
// victim pointer, stage registers and output window register
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl #(
   parameter int P_LINE = 6,
   parameter int P_SETS = 4,
   parameter int P_WAYS = 1
) (
   input  wire                                            clk,
   input  wire                                            i_rst_n,
   input  wire                                            i_p_ce,
   input  wire icache_pkg::vpo_t                          i_vpo,
   input  wire icache_pkg::ppn_t                          i_ppn_s2,
   input  wire                                            i_icinv_we,
   input  wire icache_pkg::paddr_t                        i_icinv_addr,
   input  wire                                            i_hit,
   input  wire icache_pkg::fetch_t                        i_hit_data,
   input  wire                                            i_r_beat,
   input  wire                                            i_r_last,
   input  wire icache_pkg::fetch_t                        i_rdata,
   icache_array_if.ctrl                                   array,
   output logic [icache_pkg::CONFIG_AW-P_SETS-P_LINE-1:0] o_paddr_tag,
   output logic                                           o_ar_req,
   output icache_pkg::paddr_t                             o_ar_addr,
   output logic                                           o_in_refill,
   output logic                                           o_stall_req,
   output icache_pkg::fetch_t                             o_ins,
   output logic                                           o_valid
);
   import icache_pkg::*;

   localparam int NWAYS      = 1 << P_WAYS;
   localparam int TAG_W      = CONFIG_AW - P_SETS - P_LINE;
   localparam int WIN_W      = P_LINE - P_FETCH_BYTES;
   localparam int PAYLOAD_AW = P_SETS + WIN_W;

   ic_state_e         state_q;
   ic_state_e         state_d;
   logic [P_SETS-1:0] boot_cnt;
   logic [WIN_W-1:0]  refill_cnt;
   logic [NWAYS-1:0]  free_way;
   logic [NWAYS-1:0]  s2o_free_way;
   logic              s1o_valid;
   logic              s2o_valid;
   logic              s2o_miss_inflight;
   vpo_t              s1o_vpo;
   paddr_t            s2i_paddr;
   paddr_t            s2o_paddr;
   paddr_t            inv_paddr;
   logic              s2i_miss;
   logic              fsm_idle;
   logic              refill_get_dat;

   assign fsm_idle    = (state_q == S_IDLE);
   assign s2i_paddr   = {i_ppn_s2, s1o_vpo};
   assign o_paddr_tag = s2i_paddr[CONFIG_AW-1 -: TAG_W];
   assign s2i_miss    = i_p_ce & s1o_valid & ~i_hit;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_BOOT:       if (&boot_cnt) state_d = S_IDLE;
         S_IDLE:
         begin
            if (i_icinv_we)
               state_d = S_INVALIDATE;
            else if (s2i_miss)
               state_d = S_REPLACE;
         end
         S_REPLACE:    state_d = S_REFILL;
         S_REFILL:     if (i_r_last) state_d = S_RELOAD_S1O;
         S_INVALIDATE: state_d = s2o_miss_inflight ? S_REPLACE : S_IDLE; // Resume held miss
         S_RELOAD_S1O: state_d = S_IDLE;
         default:      state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         state_q           <= S_BOOT;
         boot_cnt          <= '0;
         refill_cnt        <= '0;
         free_way          <= NWAYS'(1);
         s1o_valid         <= 1'b0;
         s2o_valid         <= 1'b0;
         s2o_miss_inflight <= 1'b0;
      end
      else
      begin
         state_q  <= state_d;
         free_way <= (free_way << 1) | (free_way >> (NWAYS - 1)); // Clock hand
         if (state_q == S_BOOT)
            boot_cnt <= boot_cnt + 1'b1;
         if (o_in_refill && i_r_beat)
            refill_cnt <= refill_cnt + 1'b1; // Wraps at end of burst
         if (i_p_ce)
         begin
            s1o_valid <= 1'b1;
            s2o_valid <= s1o_valid;
         end
         if (fsm_idle)
            s2o_miss_inflight <= s2i_miss;
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_p_ce)
      begin
         s1o_vpo   <= i_vpo;
         s2o_paddr <= s2i_paddr;
      end
      if (fsm_idle)
         inv_paddr <= i_icinv_addr;
      if (state_q == S_REPLACE)
         s2o_free_way <= free_way;   // Victim for the whole refill
   end

   // Set index by state
   always_comb
   begin
      case (state_q)
         S_BOOT:       array.line_addr = boot_cnt;
         S_INVALIDATE: array.line_addr = inv_paddr[P_LINE +: P_SETS];
         S_REPLACE:    array.line_addr = s2o_paddr[P_LINE +: P_SETS];
         S_RELOAD_S1O: array.line_addr = s1o_vpo[P_LINE +: P_SETS];
         default:      array.line_addr = i_vpo[P_LINE +: P_SETS];
      endcase
   end

   always_comb
   begin
      case (state_q)
         S_REFILL:     array.payload_addr = {s2o_paddr[P_LINE +: P_SETS], refill_cnt};
         S_RELOAD_S1O: array.payload_addr = s1o_vpo[P_FETCH_BYTES +: PAYLOAD_AW];
         default:      array.payload_addr = i_vpo[P_FETCH_BYTES +: PAYLOAD_AW];
      endcase
   end

   assign array.re        = i_p_ce | (state_q == S_RELOAD_S1O);
   assign array.tag_wdata = (state_q == S_REPLACE) ? {s2o_paddr[CONFIG_AW-1 -: TAG_W], 1'b1}
                                                   : '0;
   // Boot and invalidate clear the set in every way
   assign array.tag_we = {NWAYS{(state_q == S_BOOT) | (state_q == S_INVALIDATE)}} |
                         ({NWAYS{state_q == S_REPLACE}} & free_way);
   assign array.payload_we    = {NWAYS{o_in_refill & i_r_beat}} & s2o_free_way;
   assign array.payload_wdata = i_rdata;

   // Critical word grabbed off the bus
   assign refill_get_dat = o_in_refill & i_r_beat &
                           (s2o_paddr[P_FETCH_BYTES +: WIN_W] == refill_cnt);

   always_ff @(posedge clk)
   begin
      if (refill_get_dat)
         o_ins <= i_rdata;
      else if (i_p_ce)
         o_ins <= i_hit_data;
   end

   assign o_ar_req    = (state_q == S_REPLACE);
   assign o_ar_addr   = {s2o_paddr[CONFIG_AW-1:P_LINE], {P_LINE{1'b0}}};
   assign o_in_refill = (state_q == S_REFILL);
   assign o_stall_req = ~fsm_idle;
   assign o_valid     = s2o_valid;

endmodule

`default_nettype wire

/* source/icache_pkg.sv */
// ------------------------------------------------------------
// Instruction cache package with widths, address types and
// the main FSM state encoding
// ------------------------------------------------------------
`default_nettype none

package icache_pkg;

   localparam int CONFIG_AW          = 32;   // Physical address width
   localparam int CONFIG_P_PAGE_SIZE = 12;   // log2 of page size
   localparam int INSN_DW            = 32;
   localparam int FETCH_DW           = 2 * INSN_DW; // Two instructions per window
   localparam int P_FETCH_BYTES      = 3;    // log2(FETCH_DW/8)

   // AXI read channel is as wide as one fetch window
   localparam int AXI_AW             = CONFIG_AW;
   localparam int AXI_DW             = FETCH_DW;
   localparam int AXI_LEN_W          = 8;

   typedef logic [CONFIG_AW-1:0]                    paddr_t;
   typedef logic [CONFIG_P_PAGE_SIZE-1:0]           vpo_t;
   typedef logic [CONFIG_AW-CONFIG_P_PAGE_SIZE-1:0] ppn_t;
   typedef logic [FETCH_DW-1:0]                     fetch_t;

   typedef logic [AXI_AW-1:0]                       axi_addr_t;
   typedef logic [AXI_DW-1:0]                       axi_data_t;

   typedef enum logic [2:0] {
      S_BOOT       = 3'd0,   // Clearing tag/valid after reset
      S_IDLE       = 3'd1,
      S_REPLACE    = 3'd2,   // Victim tag write and AR request
      S_REFILL     = 3'd3,
      S_INVALIDATE = 3'd4,
      S_RELOAD_S1O = 3'd5    // Re-read stage 1 after refill
   } ic_state_e;

endpackage

`default_nettype wire

/* source/icache_top.sv */
// ------------------------------------------------------------
// Instruction cache top level with plain frontend and AXI
// read ports
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
   parameter int P_LINE = 6,
   parameter int P_SETS = 4,
   parameter int P_WAYS = 1
) (
   input  wire                              clk,
   input  wire                              i_rst_n,
   input  wire                              i_p_ce,
   input  wire icache_pkg::vpo_t            i_vpo,
   input  wire icache_pkg::ppn_t            i_ppn_s2,
   input  wire                              i_icinv_we,
   input  wire icache_pkg::paddr_t          i_icinv_addr,
   output logic                             o_stall_req,
   output icache_pkg::fetch_t               o_ins,
   output logic                             o_valid,
   // AXI read master
   input  wire                              i_arready,
   output logic                             o_arvalid,
   output icache_pkg::paddr_t               o_araddr,
   output logic [icache_pkg::AXI_LEN_W-1:0] o_arlen,
   output logic                             o_rready,
   input  wire                              i_rvalid,
   input  wire icache_pkg::fetch_t          i_rdata,
   input  wire                              i_rlast
);
   import icache_pkg::*;

   localparam int TAG_W = CONFIG_AW - P_SETS - P_LINE;

   logic [TAG_W-1:0] paddr_tag;
   logic             hit;
   fetch_t           hit_data;
   logic             ar_req;
   paddr_t           ar_addr;
   logic             in_refill;
   logic             r_beat;
   logic             r_last;

   icache_array_if #(.P_LINE(P_LINE), .P_SETS(P_SETS), .P_WAYS(P_WAYS)) u_array ();

   icache_ctrl #(
      .P_LINE (P_LINE),
      .P_SETS (P_SETS),
      .P_WAYS (P_WAYS)
   ) u_ctrl (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_p_ce       (i_p_ce),
      .i_vpo        (i_vpo),
      .i_ppn_s2     (i_ppn_s2),
      .i_icinv_we   (i_icinv_we),
      .i_icinv_addr (i_icinv_addr),
      .i_hit        (hit),
      .i_hit_data   (hit_data),
      .i_r_beat     (r_beat),
      .i_r_last     (r_last),
      .i_rdata      (i_rdata),
      .array        (u_array.ctrl),
      .o_paddr_tag  (paddr_tag),
      .o_ar_req     (ar_req),
      .o_ar_addr    (ar_addr),
      .o_in_refill  (in_refill),
      .o_stall_req  (o_stall_req),
      .o_ins        (o_ins),
      .o_valid      (o_valid)
   );

   // Raw tag/valid read is not consumed at this level
   icache_ways #(
      .P_LINE (P_LINE),
      .P_SETS (P_SETS),
      .P_WAYS (P_WAYS)
   ) u_ways (
      .clk         (clk),
      .array       (u_array.ways),
      .o_tag_v     (),
      .i_paddr_tag (paddr_tag),
      .o_hit       (hit),
      .o_hit_data  (hit_data)
   );

   icache_axi_rd #(
      .P_LINE (P_LINE)
   ) u_axi_rd (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_ar_req    (ar_req),
      .i_ar_addr   (ar_addr),
      .i_arready   (i_arready),
      .o_arvalid   (o_arvalid),
      .o_araddr    (o_araddr),
      .o_arlen     (o_arlen),
      .i_in_refill (in_refill),
      .i_rvalid    (i_rvalid),
      .i_rlast     (i_rlast),
      .o_rready    (o_rready),
      .o_r_beat    (r_beat),
      .o_r_last    (r_last)
   );

endmodule

`default_nettype wire

/* source/icache_ways.sv */
// ------------------------------------------------------------
// Per-way tag/valid and payload arrays, tag compare and
// hit-way window select
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module icache_ways #(
   parameter int P_LINE = 6,
   parameter int P_SETS = 4,
   parameter int P_WAYS = 1
) (
   input  wire                                                clk,
   icache_array_if.ways                                       array,
   output logic [(1<<P_WAYS)*(icache_pkg::CONFIG_AW-P_SETS-P_LINE+1)-1:0] o_tag_v,
   input  wire  [icache_pkg::CONFIG_AW-P_SETS-P_LINE-1:0]     i_paddr_tag,
   output logic                                               o_hit,
   output icache_pkg::fetch_t                                 o_hit_data
);
   import icache_pkg::*;

   localparam int NWAYS      = 1 << P_WAYS;
   localparam int TAG_W      = CONFIG_AW - P_SETS - P_LINE;
   localparam int TV_W       = TAG_W + 1;
   localparam int PAYLOAD_AW = P_SETS + P_LINE - P_FETCH_BYTES;

   logic [NWAYS-1:0]               hit_vec;
   logic [NWAYS-1:0][FETCH_DW-1:0] way_data;

   genvar w;

   generate
      for (w = 0; w < NWAYS; w = w + 1)
      begin : gen_way
         logic [TV_W-1:0] tag_mem [1<<P_SETS];
         fetch_t          payload_mem [1<<PAYLOAD_AW];
         logic [TV_W-1:0] tag_v_q;
         fetch_t          payload_q;

         // Tag/valid array, registered read
         always_ff @(posedge clk)
         begin
            if (array.tag_we[w])
            begin
               tag_mem[array.line_addr] <= array.tag_wdata;
            end
            if (array.re)
            begin
               tag_v_q <= tag_mem[array.line_addr];
            end
         end

         always_ff @(posedge clk)
         begin
            if (array.payload_we[w])
            begin
               payload_mem[array.payload_addr] <= array.payload_wdata;
            end
            if (array.re)
            begin
               payload_q <= payload_mem[array.payload_addr];
            end
         end

         assign o_tag_v[w*TV_W +: TV_W] = tag_v_q;
         assign way_data[w]             = payload_q;

         // Valid bit sits in the LSB
         assign hit_vec[w] = tag_v_q[0] & (tag_v_q[TV_W-1:1] == i_paddr_tag);
      end
   endgenerate

   // Lowest matching way wins
   always_comb
   begin
      o_hit_data = '0;
      for (int i = NWAYS - 1; i >= 0; i--)
      begin
         if (hit_vec[i])
         begin
            o_hit_data = way_data[i];
         end
      end
   end

   assign o_hit = |hit_vec;

endmodule

`default_nettype wire
